// File: sim.f
verilog/dcache_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_wb_buffer.sv
verilog/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module dcache_tb -f sim.f \
    --Mdir obj_dir -o dcache_sim

./obj_dir/dcache_sim 2>&1 | tee run.log

if grep -q "SIMULATION FAILED" run.log; then
    echo "run.sh: failure reported in run.log"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" run.log; then
    echo "run.sh: simulation ended without a pass line"
    exit 1
fi
echo "run.sh: done"

// File: dv/dcache_tb.sv
//////////////////////////////
// dcache testbench
// load/store table checked against a byte reference memory
//////////////////////////////
`timescale 1ns/1ps

module dcache_tb;

    localparam int          SET_BITS   = 7;
    localparam logic [31:0] SEED       = 32'hc222c19f;
    localparam int          PHASE1_LEN = 15;  // at most four lines per set up to here

    logic                   clk = 1'b0;
    logic                   rst, cpu_valid, cpu_ready, mem_err;
    dcache_pkg::cpu_req_t   cpu_req;
    dcache_pkg::data_t      cpu_rdata, mem_rd_data;
    dcache_pkg::addr_t      mem_rd_addr;
    logic                   mem_rd_valid, mem_rd_ready, mem_rd_data_valid, mem_rd_last;
    logic                   mem_wr_valid, mem_wr_ready;
    dcache_pkg::mem_wbeat_t mem_wr_beat;
    logic [63:0]            hit_count, miss_count;

    dcache_pkg::cpu_req_t stim_q [$];
    logic [7:0]           ref_mem [dcache_pkg::addr_t];     // bytes stored so far
    bit                   seen_lines [dcache_pkg::addr_t];  // phase 1 lines touched

    dcache_top #(.SET_BITS(SET_BITS)) DUT (
        .clk, .rst, .cpu_valid_i(cpu_valid), .cpu_req_i(cpu_req),
        .cpu_ready_o(cpu_ready), .cpu_rdata_o(cpu_rdata),
        .mem_rd_valid_o(mem_rd_valid), .mem_rd_addr_o(mem_rd_addr), .mem_rd_ready_i(mem_rd_ready),
        .mem_rd_data_valid_i(mem_rd_data_valid), .mem_rd_data_i(mem_rd_data),
        .mem_rd_last_i(mem_rd_last), .mem_wr_valid_o(mem_wr_valid),
        .mem_wr_beat_o(mem_wr_beat), .mem_wr_ready_i(mem_wr_ready),
        .hit_count_o(hit_count), .miss_count_o(miss_count)
    );

    dcache_mem_model #(.SEED(SEED)) u_mem (
        .clk, .rst, .rd_valid_i(mem_rd_valid), .rd_addr_i(mem_rd_addr), .rd_ready_o(mem_rd_ready),
        .rd_data_valid_o(mem_rd_data_valid), .rd_data_o(mem_rd_data), .rd_last_o(mem_rd_last),
        .wr_valid_i(mem_wr_valid), .wr_beat_i(mem_wr_beat), .wr_ready_o(mem_wr_ready),
        .err_o(mem_err)
    );

    always #10 clk = ~clk;  // 20 ns

    // same power-up rule as the memory model
    function automatic logic [7:0] init_byte(dcache_pkg::addr_t a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic [7:0] ref_byte(dcache_pkg::addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : init_byte(a);
    endfunction

    // word at addr[31:3] shifted down by the byte offset with zero fill
    function automatic dcache_pkg::data_t predict_load(dcache_pkg::addr_t a);
        dcache_pkg::data_t d;
        d = '0;
        for (int i = 0; i < 8; i++) begin
            if (int'(a[2:0]) + i < 8) d[i*8 +: 8] = ref_byte(a + i);
        end
        return d;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic add_access(input logic we, input dcache_pkg::addr_t addr,
                              input dcache_pkg::acc_size_e size, input dcache_pkg::data_t wdata);
        dcache_pkg::cpu_req_t r;
        r.addr  = addr;
        r.we    = we;
        r.size  = size;
        r.wdata = wdata;
        stim_q.push_back(r);
    endtask

    // drives one request 1 ns after an edge and waits for ready
    task automatic run_access(input dcache_pkg::cpu_req_t req, input logic phase1);
        int                edges;
        logic              was_seen;
        dcache_pkg::addr_t line;
        dcache_pkg::data_t exp;
        line      = {req.addr[31:4], 4'h0};
        was_seen  = seen_lines.exists(line);
        exp       = predict_load(req.addr);
        cpu_req   = req;
        cpu_valid = 1'b1;
        edges     = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);  // ready and rdata settled mid-cycle
        end while (!cpu_ready);
        if (!req.we) compare_value("cpu_rdata_o", cpu_rdata, exp);
        if (phase1 && was_seen) compare_value("cpu_ready_o latency", edges, 2);
        if (req.we) begin
            for (int i = 0; i < (1 << req.size); i++) ref_mem[req.addr + i] = req.wdata[i*8 +: 8];
        end
        if (phase1) seen_lines[line] = 1'b1;
        @(posedge clk);  // handshake edge
        #1 cpu_valid = 1'b0;
    endtask

    initial begin
        cpu_valid = 1'b0;
        cpu_req   = '0;
        rst       = 1'b1;
        // we, address, size, store data
        add_access(1'b0, 32'h0001_2340, dcache_pkg::SIZE_D, 64'h0);  // cold miss
        add_access(1'b0, 32'h0001_2348, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0001_2343, dcache_pkg::SIZE_B, 64'h0);
        add_access(1'b0, 32'h0001_234a, dcache_pkg::SIZE_H, 64'h0);
        add_access(1'b1, 32'h0001_2341, dcache_pkg::SIZE_B, 64'ha5);  // store hits
        add_access(1'b1, 32'h0001_2346, dcache_pkg::SIZE_H, 64'hbeef);
        add_access(1'b1, 32'h0001_234c, dcache_pkg::SIZE_W, 64'hdead_beef);
        add_access(1'b0, 32'h0001_2340, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0001_2348, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b1, 32'h0002_0058, dcache_pkg::SIZE_D, 64'h0123_4567_89ab_cdef);  // store miss
        add_access(1'b0, 32'h0002_0058, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b1, 32'h0003_0065, dcache_pkg::SIZE_B, 64'h3c);
        add_access(1'b1, 32'h0003_0062, dcache_pkg::SIZE_H, 64'h7e81);
        add_access(1'b0, 32'h0003_0060, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0005_0084, dcache_pkg::SIZE_W, 64'h0);
        // six lines in set 0x10 force dirty evictions
        add_access(1'b1, 32'h0010_0100, dcache_pkg::SIZE_D, 64'h1111_2222_3333_4444);
        add_access(1'b1, 32'h0010_0908, dcache_pkg::SIZE_W, 64'h5566_7788);
        add_access(1'b1, 32'h0010_1102, dcache_pkg::SIZE_H, 64'h99aa);
        add_access(1'b1, 32'h0010_190f, dcache_pkg::SIZE_B, 64'hbb);
        add_access(1'b1, 32'h0010_2104, dcache_pkg::SIZE_W, 64'hccdd_eeff);
        add_access(1'b1, 32'h0010_2900, dcache_pkg::SIZE_D, 64'hfedc_ba98_7654_3210);
        add_access(1'b0, 32'h0010_0100, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0010_0908, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0010_1100, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0010_1908, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0010_2100, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0010_2900, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0001_2340, dcache_pkg::SIZE_D, 64'h0);
        add_access(1'b0, 32'h0002_0058, dcache_pkg::SIZE_D, 64'h0);
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        for (int n = 0; n < stim_q.size(); n++) begin
            run_access(stim_q[n], n < PHASE1_LEN);
            if (n == PHASE1_LEN - 1) begin  // one miss per distinct line and hits for the rest
                compare_value("miss_count_o", miss_count, seen_lines.num());
                compare_value("hit_count_o", hit_count, PHASE1_LEN - seen_lines.num());
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    always @(negedge clk) begin
        if (mem_err) stop_run("memory model received a malformed write beat");
    end

    // 200 cycles per table entry plus reset
    initial begin
        #1;
        repeat (stim_q.size() * 200 + 10) @(posedge clk);
        stop_run($sformatf("timeout: table of %0d accesses did not finish", stim_q.size()));
    end

endmodule

// File: dv/dcache_mem_model.sv
//////////////////////////////
// dcache backing memory
// two-beat read bursts, write beats, random stalls
//////////////////////////////
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter logic [31:0] SEED = 32'hc222c19f
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_valid_i,
    input  dcache_pkg::addr_t      rd_addr_i,
    output logic                   rd_ready_o,
    output logic                   rd_data_valid_o,
    output dcache_pkg::data_t      rd_data_o,
    output logic                   rd_last_o,
    input  logic                   wr_valid_i,
    input  dcache_pkg::mem_wbeat_t wr_beat_i,
    output logic                   wr_ready_o,
    output logic                   err_o
);

    logic [7:0]             mem_q [dcache_pkg::addr_t];  // only bytes written back so far
    integer                 seed;
    logic                   rd_take, wr_take, rd_busy, rd_beat, wr_idx;
    dcache_pkg::addr_t      rd_addr_s, rd_base;
    dcache_pkg::mem_wbeat_t wr_beat_s;

    // power-up content, mixes every address bit
    function automatic logic [7:0] init_byte(dcache_pkg::addr_t a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic [7:0] read_byte(dcache_pkg::addr_t a);
        return mem_q.exists(a) ? mem_q[a] : init_byte(a);
    endfunction

    initial begin
        seed            = SEED;
        rd_ready_o      = 1'b0;
        rd_data_valid_o = 1'b0;
        rd_data_o       = '0;
        rd_last_o       = 1'b0;
        wr_ready_o      = 1'b0;
        err_o           = 1'b0;
        rd_busy         = 1'b0;
        rd_beat         = 1'b0;
        wr_idx          = 1'b0;
    end

    always begin
        @(negedge clk);  // mid-cycle sample, transfer closes at the next edge
        rd_take   = rd_valid_i && rd_ready_o;
        wr_take   = wr_valid_i && wr_ready_o;
        rd_addr_s = rd_addr_i;
        wr_beat_s = wr_beat_i;
        @(posedge clk);
        if (rst) begin
            rd_busy = 1'b0;
            wr_idx  = 1'b0;
        end else begin
            if (wr_take) begin
                // line aligned addr, last only on the second beat
                if (wr_beat_s.addr[3:0] != 4'h0 || wr_beat_s.last != wr_idx) begin
                    $display("memory model: bad write beat addr %h last %b beat %0d",
                             wr_beat_s.addr, wr_beat_s.last, wr_idx);
                    err_o = 1'b1;
                end
                for (int i = 0; i < 8; i++) begin
                    mem_q[wr_beat_s.addr + 8 * wr_idx + i] = wr_beat_s.data[i*8 +: 8];
                end
                wr_idx = !wr_idx;
            end
            if (rd_take) begin
                rd_base = rd_addr_s;
                rd_busy = 1'b1;
                rd_beat = 1'b0;  // low half first
            end
        end
        #1;
        rd_data_valid_o = 1'b0;
        rd_last_o       = 1'b0;
        if (rd_busy && ($random(seed) & 1)) begin  // random gap before each beat
            for (int i = 0; i < 8; i++) begin
                rd_data_o[i*8 +: 8] = read_byte(rd_base + 8 * rd_beat + i);
            end
            rd_data_valid_o = 1'b1;
            rd_last_o       = rd_beat;
            rd_busy         = !rd_beat;
            rd_beat         = 1'b1;
        end
        rd_ready_o = !rst && !rd_busy && (($random(seed) & 3) != 0);
        wr_ready_o = !rst && ($random(seed) & 1);
    end

endmodule

// File: verilog/dcache_top.sv
//////////////////////////////
// dcache top
// 4-way write-back data cache, cpu and memory ports
//////////////////////////////
`timescale 1ns/1ps

module dcache_top #(
    parameter int SET_BITS = 7  // 7 -> 8 KB
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_valid_i,
    input  dcache_pkg::cpu_req_t   cpu_req_i,
    output logic                   cpu_ready_o,
    output dcache_pkg::data_t      cpu_rdata_o,
    output logic                   mem_rd_valid_o,
    output dcache_pkg::addr_t      mem_rd_addr_o,
    input  logic                   mem_rd_ready_i,
    input  logic                   mem_rd_data_valid_i,
    input  dcache_pkg::data_t      mem_rd_data_i,
    input  logic                   mem_rd_last_i,
    output logic                   mem_wr_valid_o,
    output dcache_pkg::mem_wbeat_t mem_wr_beat_o,
    input  logic                   mem_wr_ready_i,
    output logic [63:0]            hit_count_o,
    output logic [63:0]            miss_count_o
);

    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - SET_BITS;

    logic [SET_BITS-1:0]    lookup_index, data_index;
    logic [TAG_W-1:0]       lookup_tag, victim_tag;
    logic                   hit, victim_dirty, fill_en, dirty_set_en, data_wr_en;
    dcache_pkg::way_t       hit_way, victim_way, fill_way, dirty_way, data_wr_way;
    dcache_pkg::line_strb_t data_wr_strb;
    dcache_pkg::line_t      data_wr_line;
    dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] rd_lines;
    logic                   wb_valid, wb_ready;
    dcache_pkg::wb_line_t   wb_line;

    dcache_tag_array #(.SET_BITS(SET_BITS)) u_tag (
        .clk, .rst,
        .lookup_index_i(lookup_index), .lookup_tag_i(lookup_tag),
        .fill_en_i(fill_en), .fill_way_i(fill_way),
        .dirty_set_en_i(dirty_set_en), .dirty_way_i(dirty_way),
        .hit_o(hit), .hit_way_o(hit_way),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
    );

    dcache_data_array #(.SET_BITS(SET_BITS)) u_data (
        .clk, .index_i(data_index),
        .wr_en_i(data_wr_en), .wr_way_i(data_wr_way),
        .wr_strb_i(data_wr_strb), .wr_line_i(data_wr_line),
        .rd_lines_o(rd_lines)
    );

    dcache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (
        .clk, .rst, .cpu_valid_i, .cpu_req_i, .cpu_ready_o, .cpu_rdata_o,
        .lookup_index_o(lookup_index), .lookup_tag_o(lookup_tag),
        .hit_i(hit), .hit_way_i(hit_way),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
        .fill_en_o(fill_en), .fill_way_o(fill_way),
        .dirty_set_en_o(dirty_set_en), .dirty_way_o(dirty_way),
        .data_index_o(data_index), .data_wr_en_o(data_wr_en), .data_wr_way_o(data_wr_way),
        .data_wr_strb_o(data_wr_strb), .data_wr_line_o(data_wr_line), .rd_lines_i(rd_lines),
        .wb_valid_o(wb_valid), .wb_line_o(wb_line), .wb_ready_i(wb_ready),
        .mem_rd_valid_o, .mem_rd_addr_o, .mem_rd_ready_i,
        .mem_rd_data_valid_i, .mem_rd_data_i, .mem_rd_last_i,
        .hit_count_o, .miss_count_o
    );

    dcache_wb_buffer u_wb (
        .clk, .rst,
        .wb_valid_i(wb_valid), .wb_line_i(wb_line), .wb_ready_o(wb_ready),
        .mem_wr_valid_o, .mem_wr_beat_o, .mem_wr_ready_i
    );

endmodule

// File: verilog/dcache_wb_buffer.sv
//////////////////////////////
// dcache write-back buffer
// one dirty line, sent as two write beats
//////////////////////////////
`timescale 1ns/1ps

module dcache_wb_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_valid_i,
    input  dcache_pkg::wb_line_t   wb_line_i,
    output logic                   wb_ready_o,
    output logic                   mem_wr_valid_o,
    output dcache_pkg::mem_wbeat_t mem_wr_beat_o,
    input  logic                   mem_wr_ready_i
);

    logic                 full_q;
    logic                 beat_q;  // 0 low half, 1 high half
    dcache_pkg::wb_line_t line_q;

    assign wb_ready_o     = !full_q;  // accept only when empty
    assign mem_wr_valid_o = full_q;
    assign mem_wr_beat_o  = '{addr: line_q.addr,
                              data: beat_q ? line_q.data[127:64] : line_q.data[63:0],
                              last: beat_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
            beat_q <= 1'b0;
        end else if (!full_q) begin
            if (wb_valid_i) begin
                full_q <= 1'b1;
                beat_q <= 1'b0;
            end
        end else if (mem_wr_ready_i) begin
            if (beat_q) full_q <= 1'b0;  // free after the last beat
            beat_q <= !beat_q;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid_i && !full_q) line_q <= wb_line_i;
    end

endmodule

// File: verilog/dcache_ctrl.sv
//////////////////////////////
// dcache controller
// lookup, evict, refill and store merge FSM
// plus hit/miss counters
//////////////////////////////
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int SET_BITS = 7,
    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - SET_BITS
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         cpu_valid_i,
    input  dcache_pkg::cpu_req_t                         cpu_req_i,
    output logic                                         cpu_ready_o,
    output dcache_pkg::data_t                            cpu_rdata_o,
    output logic [SET_BITS-1:0]                          lookup_index_o,
    output logic [TAG_W-1:0]                             lookup_tag_o,
    input  logic                                         hit_i,
    input  dcache_pkg::way_t                             hit_way_i,
    input  dcache_pkg::way_t                             victim_way_i,
    input  logic                                         victim_dirty_i,
    input  logic [TAG_W-1:0]                             victim_tag_i,
    output logic                                         fill_en_o,
    output dcache_pkg::way_t                             fill_way_o,
    output logic                                         dirty_set_en_o,
    output dcache_pkg::way_t                             dirty_way_o,
    output logic [SET_BITS-1:0]                          data_index_o,
    output logic                                         data_wr_en_o,
    output dcache_pkg::way_t                             data_wr_way_o,
    output dcache_pkg::line_strb_t                       data_wr_strb_o,
    output dcache_pkg::line_t                            data_wr_line_o,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] rd_lines_i,
    output logic                                         wb_valid_o,
    output dcache_pkg::wb_line_t                         wb_line_o,
    input  logic                                         wb_ready_i,
    output logic                                         mem_rd_valid_o,
    output dcache_pkg::addr_t                            mem_rd_addr_o,
    input  logic                                         mem_rd_ready_i,
    input  logic                                         mem_rd_data_valid_i,
    input  dcache_pkg::data_t                            mem_rd_data_i,
    input  logic                                         mem_rd_last_i,
    output logic [63:0]                                  hit_count_o,
    output logic [63:0]                                  miss_count_o
);

    localparam int OW = dcache_pkg::OFFSET_W;

    typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, READ_REQ, READ_DATA, FILL, RESPOND} state_e;

    state_e               state_q, state_d;
    dcache_pkg::cpu_req_t req_q;          // held for the whole access
    dcache_pkg::way_t     victim_way_q;   // latched since the rr pointer keeps moving
    logic [TAG_W-1:0]     victim_tag_q;
    dcache_pkg::line_t    fill_line_q;    // refill beats land here
    dcache_pkg::data_t    rdata_q;
    logic [63:0]          hit_cnt_q, miss_cnt_q;
    logic [OW-1:0]        off;
    logic [7:0]           size_mask, byte_strb;
    dcache_pkg::line_strb_t st_strb;
    dcache_pkg::data_t    st_data, load_word;
    dcache_pkg::line_t    st_line, merge_line, src_line;
    logic                 store_hit;

    assign off            = req_q.addr[OW-1:0];
    assign lookup_index_o = req_q.addr[OW +: SET_BITS];
    assign lookup_tag_o   = req_q.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
    // cpu address while idle so the read starts on edge 1
    assign data_index_o   = (state_q == IDLE) ? cpu_req_i.addr[OW +: SET_BITS] : lookup_index_o;

    // store strobe from size and offset
    always_comb begin
        case (req_q.size)
            dcache_pkg::SIZE_B: size_mask = 8'h01;
            dcache_pkg::SIZE_H: size_mask = 8'h03;
            dcache_pkg::SIZE_W: size_mask = 8'h0f;
            default:            size_mask = 8'hff;
        endcase
    end
    assign byte_strb = size_mask << off[2:0];
    assign st_strb   = off[3] ? {byte_strb, 8'h00} : {8'h00, byte_strb};
    assign st_data   = req_q.wdata << {off[2:0], 3'b000};
    assign st_line   = {st_data, st_data};  // strobe picks the half

    // refilled line with the store bytes on top
    always_comb begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            merge_line[b*8 +: 8] = (req_q.we && st_strb[b]) ? st_line[b*8 +: 8]
                                                            : fill_line_q[b*8 +: 8];
        end
    end

    // load result picks the 64-bit half and shifts it down with zero fill
    assign src_line  = (state_q == FILL) ? fill_line_q : rd_lines_i[hit_way_i];
    assign load_word = off[3] ? src_line[127:64] : src_line[63:0];
    assign store_hit = (state_q == LOOKUP) && hit_i && req_q.we;

    assign data_wr_en_o   = store_hit || (state_q == FILL);
    assign data_wr_way_o  = (state_q == FILL) ? victim_way_q : hit_way_i;
    assign data_wr_strb_o = (state_q == FILL) ? '1 : st_strb;
    assign data_wr_line_o = (state_q == FILL) ? merge_line : st_line;

    assign fill_en_o      = (state_q == FILL);
    assign fill_way_o     = victim_way_q;
    assign dirty_set_en_o = store_hit || (state_q == FILL && req_q.we);
    assign dirty_way_o    = data_wr_way_o;

    assign wb_valid_o     = (state_q == EVICT);
    assign wb_line_o      = '{addr: {victim_tag_q, lookup_index_o, {OW{1'b0}}},
                              data: rd_lines_i[victim_way_q]};
    // no refill while the buffer still holds a line
    assign mem_rd_valid_o = (state_q == READ_REQ) && wb_ready_i;
    assign mem_rd_addr_o  = {req_q.addr[dcache_pkg::ADDR_W-1:OW], {OW{1'b0}}};

    assign cpu_ready_o  = (state_q == RESPOND);  // one cycle only
    assign cpu_rdata_o  = rdata_q;
    assign hit_count_o  = hit_cnt_q;
    assign miss_count_o = miss_cnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (cpu_valid_i) state_d = LOOKUP;
            LOOKUP:    state_d = hit_i ? RESPOND : (victim_dirty_i ? EVICT : READ_REQ);
            EVICT:     if (wb_ready_i) state_d = READ_REQ;
            READ_REQ:  if (mem_rd_valid_o && mem_rd_ready_i) state_d = READ_DATA;
            READ_DATA: if (mem_rd_data_valid_i && mem_rd_last_i) state_d = FILL;
            FILL:      state_d = RESPOND;
            default:   state_d = IDLE;  // RESPOND
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            hit_cnt_q  <= '0;
            miss_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP && hit_i) hit_cnt_q <= hit_cnt_q + 64'd1;
            if (state_q == LOOKUP && !hit_i) miss_cnt_q <= miss_cnt_q + 64'd1;
        end
    end

    // payload regs
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cpu_valid_i) req_q <= cpu_req_i;
        if (state_q == LOOKUP) begin
            victim_way_q <= victim_way_i;
            victim_tag_q <= victim_tag_i;
        end
        if (state_q == READ_DATA && mem_rd_data_valid_i) begin
            if (mem_rd_last_i) fill_line_q[127:64] <= mem_rd_data_i;  // high half second
            else fill_line_q[63:0] <= mem_rd_data_i;
        end
        if ((state_q == LOOKUP && hit_i) || state_q == FILL) begin
            rdata_q <= load_word >> {off[2:0], 3'b000};
        end
    end

endmodule

// File: verilog/dcache_data_array.sv
//////////////////////////////
// dcache data array
// one line per set and way, registered read, byte write
//////////////////////////////
`timescale 1ns/1ps

module dcache_data_array #(
    parameter int SET_BITS = 7
) (
    input  logic                                              clk,
    input  logic [SET_BITS-1:0]                               index_i,
    input  logic                                              wr_en_i,
    input  dcache_pkg::way_t                                  wr_way_i,
    input  dcache_pkg::line_strb_t                            wr_strb_i,
    input  dcache_pkg::line_t                                 wr_line_i,
    output dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]      rd_lines_o
);

    localparam int NUM_SETS = 2 ** SET_BITS;

    dcache_pkg::line_t mem_q [dcache_pkg::NUM_WAYS][NUM_SETS];

    // byte merge under strobe, only the selected way
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
                if (wr_strb_i[b]) mem_q[wr_way_i][index_i][b*8 +: 8] <= wr_line_i[b*8 +: 8];
            end
        end
    end

    // all ways read together, old data on a same-cycle write
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            rd_lines_o[w] <= mem_q[w][index_i];
        end
    end

endmodule

// File: verilog/dcache_tag_array.sv
//////////////////////////////
// dcache tag array
// tag/valid/dirty per set and way, hit compare, victim pick
//////////////////////////////
`timescale 1ns/1ps

module dcache_tag_array #(
    parameter int SET_BITS = 7,
    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - SET_BITS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [SET_BITS-1:0]   lookup_index_i,
    input  logic [TAG_W-1:0]      lookup_tag_i,
    input  logic                  fill_en_i,
    input  dcache_pkg::way_t      fill_way_i,
    input  logic                  dirty_set_en_i,
    input  dcache_pkg::way_t      dirty_way_i,
    output logic                  hit_o,
    output dcache_pkg::way_t      hit_way_o,
    output dcache_pkg::way_t      victim_way_o,
    output logic                  victim_dirty_o,
    output logic [TAG_W-1:0]      victim_tag_o
);

    localparam int NUM_SETS = 2 ** SET_BITS;
    localparam int NW       = dcache_pkg::NUM_WAYS;

    logic [TAG_W-1:0] tag_q   [NUM_SETS][NW];
    logic [NW-1:0]    valid_q [NUM_SETS];
    logic [NW-1:0]    dirty_q [NUM_SETS];
    logic [NW-1:0]    hit_vec;
    dcache_pkg::way_t rr_q;  // free running replacement pointer

    // compare all ways of the set at once
    always_comb begin
        hit_vec   = '0;
        hit_way_o = '0;
        for (int w = 0; w < NW; w++) begin
            hit_vec[w] = valid_q[lookup_index_i][w] && (tag_q[lookup_index_i][w] == lookup_tag_i);
            if (hit_vec[w]) hit_way_o = dcache_pkg::way_t'(w);  // at most one match
        end
        hit_o = |hit_vec;
    end

    // lowest invalid way wins, else the rr pointer
    always_comb begin
        victim_way_o = rr_q;
        for (int w = NW - 1; w >= 0; w--) begin
            if (!valid_q[lookup_index_i][w]) victim_way_o = dcache_pkg::way_t'(w);
        end
    end

    assign victim_dirty_o = dirty_q[lookup_index_i][victim_way_o];
    assign victim_tag_o   = tag_q[lookup_index_i][victim_way_o];

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_q <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (!fill_en_i) rr_q <= rr_q + 2'd1;  // moves while no refill lands
            if (fill_en_i) begin
                valid_q[lookup_index_i][fill_way_i] <= 1'b1;
                dirty_q[lookup_index_i][fill_way_i] <= dirty_set_en_i;  // store miss -> dirty
            end else if (dirty_set_en_i) begin
                dirty_q[lookup_index_i][dirty_way_i] <= 1'b1;
            end
        end
    end

    // new tag written on refill
    always_ff @(posedge clk) begin
        if (fill_en_i) tag_q[lookup_index_i][fill_way_i] <= lookup_tag_i;
    end

endmodule

// File: verilog/dcache_pkg.sv
//////////////////////////////
// dcache shared definitions
// widths, vector types, access size and bus structs
//////////////////////////////
package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;  // cpu port and memory beat
    localparam int LINE_BYTES = 16;
    localparam int OFFSET_W   = 4;   // byte offset inside a line
    localparam int NUM_WAYS   = 4;

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [DATA_W-1:0]       data_t;
    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [LINE_BYTES-1:0]   line_strb_t;
    typedef logic [1:0]              way_t;

    // access width, all naturally aligned
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } acc_size_e;

    typedef struct packed {
        addr_t     addr;
        logic      we;     // 1 store, 0 load
        acc_size_e size;
        data_t     wdata;  // store data, lsb aligned
    } cpu_req_t;

    // one beat of a write-back burst
    typedef struct packed {
        addr_t addr;  // line aligned, same on both beats
        data_t data;
        logic  last;
    } mem_wbeat_t;

    // evicted line on its way to the buffer
    typedef struct packed {
        addr_t addr;
        line_t data;
    } wb_line_t;

endpackage
